//--- all.f
logic/cpu_pkg.sv
logic/control_sequencer.sv
logic/system_bus.sv
logic/register_file.sv
logic/special_registers.sv
logic/alu.sv
logic/cpu_top.sv
test/cpu_tb.sv

//--- logic/alu.sv
module alu (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::word_t y,
	input cpu_pkg::word_t bus,
	output cpu_pkg::word_t zlo,
	output cpu_pkg::word_t zhi
);
	import cpu_pkg::*;

	logic [4:0] amt;
	logic [2*word_w-1:0] doubled;
	logic [2*word_w-1:0] rot_r;
	logic [2*word_w-1:0] rot_l;
	logic signed [2*word_w-1:0] y_wide;
	logic signed [2*word_w-1:0] b_wide;
	logic signed [2*word_w-1:0] product;
	word_t narrow;
	logic [2*word_w-1:0] result;
	logic [2*word_w-1:0] z;

	// Shift amount comes from the low bits of the bus operand
	assign amt = bus[4:0];

	// Rotates out of a doubled copy of y
	assign doubled = {y, y};
	assign rot_r = doubled >> amt;
	assign rot_l = doubled << amt;

	assign y_wide = {{word_w{y[word_w-1]}}, y};
	assign b_wide = {{word_w{bus[word_w-1]}}, bus};
	assign product = y_wide * b_wide;

	always_comb begin
		case (ctrl.alu_op)
			alu_pass_b: narrow = bus;
			alu_inc_b: narrow = bus + word_t'(1);
			alu_add: narrow = y + bus;
			alu_sub: narrow = y - bus;
			alu_and: narrow = y & bus;
			alu_or: narrow = y | bus;
			alu_shr: narrow = y >> amt;
			alu_shra: narrow = $signed(y) >>> amt;
			alu_shl: narrow = y << amt;
			alu_ror: narrow = rot_r[word_w-1:0];
			alu_rol: narrow = rot_l[2*word_w-1:word_w];
			alu_neg: narrow = -bus;
			alu_not: narrow = ~bus;
			default: narrow = product[word_w-1:0];
		endcase
	end

	// Only mul fills the high word with real data
	always_comb begin
		if (ctrl.alu_op == alu_mul)
			result = product;
		else
			result = {{word_w{narrow[word_w-1]}}, narrow};
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			z <= '0;
		else if (ctrl.z_ld)
			z <= result;
	end

	assign zlo = z[word_w-1:0];
	assign zhi = z[2*word_w-1:word_w];

endmodule

//--- logic/control_sequencer.sv
module control_sequencer #(
	parameter int reg_count = 16
) (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::word_t ir,
	output cpu_pkg::ctrl_t ctrl,
	output logic halted
);
	import cpu_pkg::*;

	localparam int idx_w = $clog2(reg_count);

	logic [3:0] step;
	logic [3:0] last_step;
	logic active;
	logic is_halt;
	logic two_operand;
	logic uses_const;
	opcode_t opcode;
	reg_idx_t ra;
	reg_idx_t rb;
	reg_idx_t rc;
	alu_op_t exec_op;
	ctrl_t decoded;

	// Register numbers beyond the file size wrap around
	function automatic reg_idx_t limit_idx(input reg_idx_t field);
		return reg_idx_t'(field[idx_w-1:0]);
	endfunction

	assign opcode = instr_opcode(ir);
	assign ra = limit_idx(instr_ra(ir));
	assign rb = limit_idx(instr_rb(ir));
	assign rc = limit_idx(instr_rc(ir));

	assign is_halt = active && (step == 4'd4) && (opcode == op_halt);
	assign halted = is_halt && rst_n;

	// Opcode classes
	always_comb begin
		two_operand = 1'b1;
		uses_const = 1'b0;
		last_step = 4'd6;
		exec_op = alu_add;
		case (opcode)
			op_add, op_addi, op_ldi: exec_op = alu_add;
			op_sub: exec_op = alu_sub;
			op_and, op_andi: exec_op = alu_and;
			op_or, op_ori: exec_op = alu_or;
			op_shr: exec_op = alu_shr;
			op_shra: exec_op = alu_shra;
			op_shl: exec_op = alu_shl;
			op_ror: exec_op = alu_ror;
			op_rol: exec_op = alu_rol;
			op_mul: begin
				exec_op = alu_mul;
				last_step = 4'd7;
			end
			op_ld: last_step = 4'd9;
			op_st: last_step = 4'd8;
			op_neg, op_not: begin
				two_operand = 1'b0;
				exec_op = (opcode == op_neg) ? alu_neg : alu_not;
				last_step = 4'd5;
			end
			default: begin
				// mfhi, mflo, halt and unused codes
				two_operand = 1'b0;
				last_step = 4'd4;
			end
		endcase
		case (opcode)
			op_addi, op_andi, op_ori, op_ldi, op_ld, op_st: uses_const = 1'b1;
			default: uses_const = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step <= 4'd0;
			active <= 1'b0;
		end else begin
			active <= 1'b1;
			if (active && !is_halt) begin
				if (step >= 4'd4 && step == last_step)
					step <= 4'd0;
				else
					step <= step + 4'd1;
			end
		end
	end

	always_comb begin
		decoded = '0;
		if (step < 4'd4) begin
			// Instruction fetch
			case (step)
				4'd0: begin
					decoded.bus_src = src_pc;
					decoded.mar_ld = 1'b1;
					decoded.alu_op = alu_inc_b;
					decoded.z_ld = 1'b1;
				end
				4'd1: begin
					decoded.bus_src = src_zlo;
					decoded.pc_ld = 1'b1;
					decoded.mem_rd = 1'b1;
				end
				4'd2: begin
					decoded.mdr_ld = 1'b1;
					decoded.mdr_from_mem = 1'b1;
				end
				default: begin
					decoded.bus_src = src_mdr;
					decoded.ir_ld = 1'b1;
				end
			endcase
		end else if (two_operand) begin
			case (step)
				4'd4: begin
					decoded.bus_src = src_gpr;
					decoded.gpr_rd_idx = rb;
					decoded.y_ld = 1'b1;
				end
				4'd5: begin
					decoded.bus_src = uses_const ? src_const : src_gpr;
					decoded.gpr_rd_idx = rc;
					decoded.alu_op = exec_op;
					decoded.z_ld = 1'b1;
				end
				default: begin
					case (opcode)
						op_mul: begin
							decoded.bus_src = (step == 4'd6) ? src_zlo : src_zhi;
							decoded.lo_ld = (step == 4'd6);
							decoded.hi_ld = (step == 4'd7);
						end
						op_ld, op_st: begin
							case (step)
								4'd6: begin
									decoded.bus_src = src_zlo;
									decoded.mar_ld = 1'b1;
								end
								4'd7: begin
									// Loads read here, stores fill MDR from Ra
									decoded.mem_rd = (opcode == op_ld);
									decoded.bus_src = (opcode == op_st) ? src_gpr : src_none;
									decoded.gpr_rd_idx = ra;
									decoded.mdr_ld = (opcode == op_st);
								end
								4'd8: begin
									decoded.mem_wr = (opcode == op_st);
									decoded.mdr_ld = (opcode == op_ld);
									decoded.mdr_from_mem = (opcode == op_ld);
								end
								default: begin
									decoded.bus_src = src_mdr;
									decoded.gpr_wr = 1'b1;
									decoded.gpr_wr_idx = ra;
								end
							endcase
						end
						default: begin
							decoded.bus_src = src_zlo;
							decoded.gpr_wr = 1'b1;
							decoded.gpr_wr_idx = ra;
						end
					endcase
				end
			endcase
		end else begin
			case (opcode)
				op_neg, op_not: begin
					if (step == 4'd4) begin
						decoded.bus_src = src_gpr;
						decoded.gpr_rd_idx = rb;
						decoded.alu_op = exec_op;
						decoded.z_ld = 1'b1;
					end else begin
						decoded.bus_src = src_zlo;
						decoded.gpr_wr = 1'b1;
						decoded.gpr_wr_idx = ra;
					end
				end
				op_mfhi, op_mflo: begin
					decoded.bus_src = (opcode == op_mfhi) ? src_hi : src_lo;
					decoded.gpr_wr = 1'b1;
					decoded.gpr_wr_idx = ra;
				end
				default: decoded = '0;
			endcase
		end
	end

	// Nothing moves until the first cycle out of reset
	assign ctrl = (active && rst_n) ? decoded : '0;

endmodule

//--- logic/cpu_pkg.sv
package cpu_pkg;

	localparam int word_w = 32;
	localparam int reg_idx_w = 4;
	localparam int const_w = 19;

	// Instruction field positions
	localparam int opcode_lsb = 27;
	localparam int ra_lsb = 23;
	localparam int rb_lsb = 19;
	localparam int rc_lsb = 15;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// Opcode 16 stays free for div
	typedef enum logic [4:0] {
		op_ld = 5'd0,
		op_ldi = 5'd1,
		op_st = 5'd2,
		op_add = 5'd3,
		op_sub = 5'd4,
		op_shr = 5'd5,
		op_shra = 5'd6,
		op_shl = 5'd7,
		op_ror = 5'd8,
		op_rol = 5'd9,
		op_and = 5'd10,
		op_or = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori = 5'd14,
		op_mul = 5'd15,
		op_neg = 5'd17,
		op_not = 5'd18,
		op_mfhi = 5'd19,
		op_mflo = 5'd20,
		op_halt = 5'd31
	} opcode_t;

	// Peers that may drive the internal bus
	typedef enum logic [3:0] {
		src_none,
		src_gpr,
		src_pc,
		src_mdr,
		src_zlo,
		src_zhi,
		src_hi,
		src_lo,
		src_const
	} bus_src_t;

	typedef enum logic [3:0] {
		alu_pass_b,
		alu_inc_b,
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_shr,
		alu_shra,
		alu_shl,
		alu_ror,
		alu_rol,
		alu_mul,
		alu_neg,
		alu_not
	} alu_op_t;

	// One control step
	typedef struct packed {
		bus_src_t bus_src;
		reg_idx_t gpr_rd_idx;
		reg_idx_t gpr_wr_idx;
		logic gpr_wr;
		logic pc_ld;
		logic mar_ld;
		logic mdr_ld;
		logic ir_ld;
		logic y_ld;
		logic z_ld;
		logic hi_ld;
		logic lo_ld;
		logic mdr_from_mem;
		alu_op_t alu_op;
		logic mem_rd;
		logic mem_wr;
	} ctrl_t;

	typedef struct packed {
		logic rd;
		logic wr;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	function automatic opcode_t instr_opcode(input word_t instr);
		return opcode_t'(instr[opcode_lsb +: 5]);
	endfunction

	function automatic reg_idx_t instr_ra(input word_t instr);
		return instr[ra_lsb +: reg_idx_w];
	endfunction

	function automatic reg_idx_t instr_rb(input word_t instr);
		return instr[rb_lsb +: reg_idx_w];
	endfunction

	function automatic reg_idx_t instr_rc(input word_t instr);
		return instr[rc_lsb +: reg_idx_w];
	endfunction

endpackage

//--- logic/cpu_top.sv
module cpu_top #(
	parameter int reg_count = 16
) (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::word_t mem_rdata,
	output cpu_pkg::mem_req_t mem_req,
	output logic halted
);
	import cpu_pkg::*;

	ctrl_t ctrl;
	word_t bus;
	word_t gpr_data;
	word_t pc;
	word_t mdr;
	word_t ir;
	word_t y;
	word_t hi;
	word_t lo;
	word_t zlo;
	word_t zhi;

	control_sequencer #(
		.reg_count(reg_count)
	) u_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.ir(ir),
		.ctrl(ctrl),
		.halted(halted)
	);

	system_bus u_bus (
		.ctrl(ctrl),
		.gpr_data(gpr_data),
		.pc(pc),
		.mdr(mdr),
		.hi(hi),
		.lo(lo),
		.zlo(zlo),
		.zhi(zhi),
		.ir(ir),
		.bus(bus)
	);

	register_file #(
		.reg_count(reg_count)
	) u_gpr (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.bus(bus),
		.gpr_data(gpr_data)
	);

	special_registers u_special (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.bus(bus),
		.mem_rdata(mem_rdata),
		.pc(pc),
		.mdr(mdr),
		.ir(ir),
		.y(y),
		.hi(hi),
		.lo(lo),
		.mem_req(mem_req)
	);

	alu u_alu (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.y(y),
		.bus(bus),
		.zlo(zlo),
		.zhi(zhi)
	);

endmodule

//--- logic/register_file.sv
module register_file #(
	parameter int reg_count = 16
) (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::word_t bus,
	output cpu_pkg::word_t gpr_data
);
	import cpu_pkg::*;

	localparam int idx_w = $clog2(reg_count);

	word_t regs [reg_count];
	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] wr_idx;

	assign rd_idx = ctrl.gpr_rd_idx[idx_w-1:0];
	assign wr_idx = ctrl.gpr_wr_idx[idx_w-1:0];

	// Write port from the bus
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (ctrl.gpr_wr) begin
			regs[wr_idx] <= bus;
		end
	end

	// Single read port onto the bus
	assign gpr_data = regs[rd_idx];

endmodule

//--- logic/special_registers.sv
module special_registers (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::word_t bus,
	input cpu_pkg::word_t mem_rdata,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t mdr,
	output cpu_pkg::word_t ir,
	output cpu_pkg::word_t y,
	output cpu_pkg::word_t hi,
	output cpu_pkg::word_t lo,
	output cpu_pkg::mem_req_t mem_req
);
	import cpu_pkg::*;

	word_t mar;

	// Execution always starts at address 0
	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0;
		else if (ctrl.pc_ld)
			pc <= bus;
	end

	always_ff @(posedge clk) begin
		if (ctrl.mar_ld)
			mar <= bus;
		if (ctrl.ir_ld)
			ir <= bus;
		if (ctrl.y_ld)
			y <= bus;
	end

	// MDR sits between memory and bus
	always_ff @(posedge clk) begin
		if (ctrl.mdr_ld) begin
			if (ctrl.mdr_from_mem)
				mdr <= mem_rdata;
			else
				mdr <= bus;
		end
	end

	// HI/LO only written by the mul tail steps
	always_ff @(posedge clk) begin
		if (ctrl.hi_ld)
			hi <= bus;
		if (ctrl.lo_ld)
			lo <= bus;
	end

	always_comb begin
		mem_req.rd = ctrl.mem_rd;
		mem_req.wr = ctrl.mem_wr;
		mem_req.addr = mar;
		mem_req.wdata = mdr;
	end

endmodule

//--- logic/system_bus.sv
module system_bus (
	input cpu_pkg::ctrl_t ctrl,
	input cpu_pkg::word_t gpr_data,
	input cpu_pkg::word_t pc,
	input cpu_pkg::word_t mdr,
	input cpu_pkg::word_t hi,
	input cpu_pkg::word_t lo,
	input cpu_pkg::word_t zlo,
	input cpu_pkg::word_t zhi,
	input cpu_pkg::word_t ir,
	output cpu_pkg::word_t bus
);
	import cpu_pkg::*;

	word_t imm;

	// Sign-extended constant field of IR
	assign imm = {{(word_w - const_w){ir[const_w-1]}}, ir[const_w-1:0]};

	// Exactly one peer holds the bus per step
	always_comb begin
		case (ctrl.bus_src)
			src_gpr: bus = gpr_data;
			src_pc: bus = pc;
			src_mdr: bus = mdr;
			src_zlo: bus = zlo;
			src_zhi: bus = zhi;
			src_hi: bus = hi;
			src_lo: bus = lo;
			src_const: bus = imm;
			default: bus = '0;
		endcase
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module cpu_tb \
	-f all.f -o cpu_sim || exit 1
out="$(./obj_dir/cpu_sim)"
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

//--- test/cpu_tb.sv
module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	localparam int test_count = 6;
	localparam int cycles_per_test = 2000;
	localparam int clk_period = 4;
	localparam int run_limit = 1500;

	logic clk = 1'b0;
	logic rst_n;
	logic load_image;
	word_t mem_rdata = '0;
	mem_req_t mem_req;
	logic halted;

	word_t mem [256];
	word_t image [256];
	int write_count = 0;
	int error_count = 0;
	int check_count = 0;
	int prog_addr;
	logic [31:0] lfsr_state = 32'd85;

	cpu_top #(
		.reg_count(16)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.mem_rdata(mem_rdata),
		.mem_req(mem_req),
		.halted(halted)
	);

	always #(clk_period / 2) clk = ~clk;

	// Memory model answering rd one cycle later
	always @(posedge clk) begin
		if (mem_req.rd)
			mem_rdata <= mem[mem_req.addr[7:0]];
		if (load_image) begin
			mem <= image;
		end else if (mem_req.wr) begin
			mem[mem_req.addr[7:0]] <= mem_req.wdata;
			write_count <= write_count + 1;
		end
	end

	// Galois LFSR stepped once per bit taken
	function automatic word_t lfsr_take(input int bits);
		word_t value;
		value = '0;
		for (int i = 0; i < bits; i++) begin
			value = {value[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return value;
	endfunction

	function automatic word_t fill_word(input int addr);
		return {8'hf0, addr[7:0], ~addr[7:0], addr[7:0]};
	endfunction

	function automatic word_t sext19(input int c);
		logic [18:0] field;
		field = 19'(c);
		return {{13{field[18]}}, field};
	endfunction

	function automatic word_t enc_reg(input opcode_t op, input int ra, input int rb,
			input int rc);
		return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
	endfunction

	function automatic word_t enc_imm(input opcode_t op, input int ra, input int rb,
			input int c);
		return {op, 4'(ra), 4'(rb), 19'(c)};
	endfunction

	// Shift and rotate results from the low 5 bits of the amount
	function automatic word_t shift_expect(input opcode_t op, input word_t value,
			input word_t amount);
		int n;
		logic [63:0] sign_fill;
		n = int'(amount[4:0]);
		sign_fill = {{32{value[31]}}, value} >> n;
		case (op)
			op_shr: return value >> n;
			op_shra: return sign_fill[31:0];
			op_shl: return value << n;
			op_ror: return (value >> n) | (value << (32 - n));
			default: return (value << n) | (value >> (32 - n));
		endcase
	endfunction

	task automatic begin_program();
		for (int i = 0; i < 256; i++)
			image[i[7:0]] = fill_word(i);
		prog_addr = 0;
	endtask

	task automatic emit(input word_t instr);
		image[prog_addr[7:0]] = instr;
		prog_addr++;
	endtask

	task automatic set_word(input word_t addr, input word_t value);
		image[addr[7:0]] = value;
	endtask

	task automatic pulse_reset(input logic load);
		@(posedge clk);
		rst_n <= 1'b0;
		load_image <= load;
		@(posedge clk);
		load_image <= 1'b0;
		repeat (9) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_halted(input string name);
		int cycles;
		cycles = 0;
		while (!halted && cycles < run_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			error_count++;
			$display("%s: halted did not rise within %0d cycles", name, run_limit);
		end
	endtask

	task automatic run_program(input string name);
		pulse_reset(1'b1);
		wait_halted(name);
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input word_t addr, input word_t expected);
		check_value(name, expected, mem[addr[7:0]]);
	endtask

	task automatic test_ldi_st();
		int c2;
		c2 = int'(lfsr_take(12)) - 2048;
		begin_program();
		emit(enc_imm(op_ldi, 1, 0, -5));
		emit(enc_imm(op_st, 1, 0, 'hc0));
		emit(enc_imm(op_ldi, 2, 0, 'h40));
		emit(enc_imm(op_ldi, 3, 2, c2));
		emit(enc_imm(op_st, 3, 2, 'h81));
		emit(enc_imm(op_ldi, 4, 0, 'hd0));
		// Negative offset from a base register
		emit(enc_imm(op_st, 1, 4, -3));
		emit(enc_imm(op_ldi, 5, 0, -262144));
		emit(enc_imm(op_st, 5, 0, 'hc2));
		emit(enc_reg(op_halt, 0, 0, 0));
		run_program("ldi_st");
		check_word("ldi_st negative constant", 'hc0, sext19(-5));
		check_word("ldi_st base plus constant", 32'h40 + sext19('h81), 32'h40 + sext19(c2));
		check_word("ldi_st negative offset", 32'hd0 + sext19(-3), sext19(-5));
		check_word("ldi_st most negative", 'hc2, sext19(-262144));
	endtask

	task automatic test_reg_alu();
		word_t a;
		word_t b;
		for (int round = 0; round < 2; round++) begin
			a = lfsr_take(32);
			b = lfsr_take(32);
			begin_program();
			set_word('h80, a);
			set_word('h81, b);
			emit(enc_imm(op_ld, 1, 0, 'h80));
			emit(enc_imm(op_ld, 2, 0, 'h81));
			emit(enc_reg(op_add, 3, 1, 2));
			emit(enc_reg(op_sub, 4, 1, 2));
			emit(enc_reg(op_and, 5, 1, 2));
			emit(enc_reg(op_or, 6, 1, 2));
			emit(enc_reg(op_neg, 7, 1, 0));
			emit(enc_reg(op_not, 8, 2, 0));
			for (int r = 3; r <= 8; r++)
				emit(enc_imm(op_st, r, 0, 'hc0 + r - 3));
			emit(enc_reg(op_halt, 0, 0, 0));
			run_program("reg_alu");
			check_word($sformatf("reg_alu add round %0d", round), 'hc0, a + b);
			check_word($sformatf("reg_alu sub round %0d", round), 'hc1, a - b);
			check_word($sformatf("reg_alu and round %0d", round), 'hc2, a & b);
			check_word($sformatf("reg_alu or round %0d", round), 'hc3, a | b);
			check_word($sformatf("reg_alu neg round %0d", round), 'hc4, 32'd0 - a);
			check_word($sformatf("reg_alu not round %0d", round), 'hc5, ~b);
		end
	endtask

	task automatic test_shifts();
		word_t value;
		word_t amounts [4];
		opcode_t shift_ops [5];
		value = lfsr_take(32) | 32'h8000_0000;
		amounts = '{32'd0, 32'd1, 32'd31, lfsr_take(32)};
		shift_ops = '{op_shr, op_shra, op_shl, op_ror, op_rol};
		begin_program();
		set_word('h80, value);
		emit(enc_imm(op_ld, 1, 0, 'h80));
		for (int k = 0; k < 4; k++) begin
			set_word('h81 + k, amounts[k]);
			emit(enc_imm(op_ld, 2, 0, 'h81 + k));
			for (int j = 0; j < 5; j++) begin
				emit(enc_reg(shift_ops[j], 3, 1, 2));
				emit(enc_imm(op_st, 3, 0, 'hc0 + 5 * k + j));
			end
		end
		emit(enc_reg(op_halt, 0, 0, 0));
		run_program("shifts");
		for (int k = 0; k < 4; k++)
			for (int j = 0; j < 5; j++)
				check_word($sformatf("shifts op %0d amount %h", j, amounts[k]), 'hc0 + 5 * k + j,
					shift_expect(shift_ops[j], value, amounts[k]));
	endtask

	task automatic test_imm_ld();
		word_t a;
		word_t d;
		int c1;
		int c2;
		int c3;
		a = lfsr_take(32);
		d = lfsr_take(32);
		c1 = int'(lfsr_take(19));
		c2 = int'(lfsr_take(19));
		c3 = int'(lfsr_take(19));
		begin_program();
		set_word('h80, a);
		set_word('h82, d);
		emit(enc_imm(op_ld, 1, 0, 'h80));
		emit(enc_imm(op_addi, 2, 1, c1));
		emit(enc_imm(op_andi, 3, 1, c2));
		emit(enc_imm(op_ori, 4, 1, c3));
		// Load through a base register at 0x70 + 0x12
		emit(enc_imm(op_ldi, 5, 0, 'h70));
		emit(enc_imm(op_ld, 6, 5, 'h12));
		emit(enc_imm(op_st, 2, 0, 'hc0));
		emit(enc_imm(op_st, 3, 0, 'hc1));
		emit(enc_imm(op_st, 4, 0, 'hc2));
		emit(enc_imm(op_st, 6, 0, 'hc3));
		emit(enc_reg(op_halt, 0, 0, 0));
		run_program("imm_ld");
		check_word("imm_ld addi", 'hc0, a + sext19(c1));
		check_word("imm_ld andi", 'hc1, a & sext19(c2));
		check_word("imm_ld ori", 'hc2, a | sext19(c3));
		check_word("imm_ld ld", 'hc3, d);
	endtask

	task automatic test_mul();
		word_t lhs [3];
		word_t rhs [3];
		logic [63:0] product;
		lhs[0] = lfsr_take(32);
		rhs[0] = lfsr_take(32);
		lhs[1] = lfsr_take(32) | 32'h8000_0000;
		rhs[1] = lfsr_take(32) & 32'h7fff_ffff;
		lhs[2] = lfsr_take(32) | 32'h8000_0000;
		rhs[2] = lfsr_take(32) | 32'h8000_0000;
		begin_program();
		for (int i = 0; i < 3; i++) begin
			set_word('h80 + 2 * i, lhs[i]);
			set_word('h81 + 2 * i, rhs[i]);
			emit(enc_imm(op_ld, 1, 0, 'h80 + 2 * i));
			emit(enc_imm(op_ld, 2, 0, 'h81 + 2 * i));
			emit(enc_reg(op_mul, 0, 1, 2));
			emit(enc_reg(op_mfhi, 3, 0, 0));
			emit(enc_reg(op_mflo, 4, 0, 0));
			emit(enc_imm(op_st, 3, 0, 'hc0 + 2 * i));
			emit(enc_imm(op_st, 4, 0, 'hc1 + 2 * i));
		end
		emit(enc_reg(op_halt, 0, 0, 0));
		run_program("mul");
		for (int i = 0; i < 3; i++) begin
			product = longint'($signed(lhs[i])) * longint'($signed(rhs[i]));
			check_word($sformatf("mul hi pair %0d", i), 'hc0 + 2 * i, product[63:32]);
			check_word($sformatf("mul lo pair %0d", i), 'hc1 + 2 * i, product[31:0]);
		end
	endtask

	task automatic test_halt_reset();
		logic stayed_high;
		int writes_before;
		int cycles;
		word_t init;
		begin_program();
		emit(enc_imm(op_ldi, 1, 0, 7));
		emit(enc_imm(op_st, 1, 0, 'hc0));
		emit(enc_reg(op_halt, 0, 0, 0));
		// Never reached
		emit(enc_imm(op_st, 1, 0, 'hc1));
		emit(enc_imm(op_st, 1, 0, 'hc2));
		pulse_reset(1'b1);
		wait_halted("halt");
		writes_before = write_count;
		stayed_high = 1'b1;
		repeat (30) begin
			@(negedge clk);
			if (!halted)
				stayed_high = 1'b0;
		end
		if (!stayed_high) begin
			error_count++;
			$display("halt: halted dropped after it rose");
		end
		if (write_count != writes_before) begin
			error_count++;
			$display("halt: memory was written after halted rose");
		end
		check_word("halt store before", 'hc0, 32'd7);
		check_word("halt no store after", 'hc1, fill_word('hc1));

		// Counter in memory shows whether the program ran twice
		init = lfsr_take(32);
		begin_program();
		set_word('h90, init);
		emit(enc_imm(op_ld, 1, 0, 'h90));
		emit(enc_imm(op_addi, 1, 1, 1));
		emit(enc_imm(op_st, 1, 0, 'h90));
		for (int r = 2; r < 6; r++)
			emit(enc_imm(op_ldi, r, 0, r));
		emit(enc_reg(op_halt, 0, 0, 0));
		pulse_reset(1'b1);
		writes_before = write_count;
		cycles = 0;
		while (write_count == writes_before && cycles < run_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (write_count == writes_before) begin
			error_count++;
			$display("reset: the store before the mid-program reset never happened");
		end
		repeat (3) @(posedge clk);
		pulse_reset(1'b0);
		cycles = 0;
		while (!mem_req.rd && cycles < run_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!mem_req.rd) begin
			error_count++;
			$display("reset: no fetch after the mid-program reset");
		end
		check_value("reset first fetch address", '0, mem_req.addr);
		wait_halted("reset");
		check_word("reset restart count", 'h90, init + 32'd2);
	endtask

	// Watchdog sized from the number of tests
	initial begin
		#(test_count * cycles_per_test * clk_period);
		$display("watchdog: run did not finish within %0d cycles", test_count * cycles_per_test);
		$display("sim failed");
		$finish;
	end

	initial begin
		rst_n <= 1'b0;
		load_image <= 1'b0;
		test_ldi_st();
		test_reg_alu();
		test_shifts();
		test_imm_ld();
		test_mul();
		test_halt_reset();
		$display("errors: %0d in %0d checks", error_count, check_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
